/* vlog.f */
+incdir+common
common/cache_pkg.sv
common/lsu_pkg.sv
source/dual_port_ram.sv
store_buffer/store_buffer.sv
source/commit_counter.sv
source/drain_fsm.sv
dcache/dcache_pipe.sv
source/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_dcache.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_dcache
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_dcache.sv */
module tb_dcache
    import cache_pkg::*;
    import lsu_pkg::*;
();

    typedef enum logic [2:0] {
        OP_LOAD,
        OP_STORE,
        OP_REFILL,
        OP_COMMIT,
        OP_IDLE,
        OP_DRAIN,
        OP_HELD_LOAD
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        mem_size_e   size;
        logic        sgn;
        word_t       data;
        logic [3:0]  strb;
        way_mask_t   way;
        logic        exp_hit;
        word_t       exp_data;
    } row_t;

    // line A sits in set 5, line B in set 6 word 0
    localparam logic [31:0] LINE_A  = 32'h1234_5450;
    localparam logic [31:0] LINE_B  = 32'h1234_5460;
    // other tag, same word index as line B
    localparam logic [31:0] MISS_ST = 32'h5678_9460;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic [31:0] req_addr;
    mem_size_e   req_size;
    logic        req_signed;
    word_t       req_wdata;
    logic [3:0]  req_strb;
    logic        ready;
    logic        resp_valid;
    logic        resp_hit;
    word_t       resp_rdata;
    logic        refill_valid;
    logic [31:0] refill_addr;
    way_mask_t   refill_way;
    word_t       refill_data;
    logic        commit;
    logic        sb_empty;

    row_t  table_q[$];
    word_t line_a[4];
    word_t line_b;
    word_t refill_words[5];
    int    seed;
    int    value_errors = 0;
    int    other_errors = 0;
    int    cycle_count = 0;
    int    max_cycles = 0;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(3)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

    dcache_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid),
        .req_addr_i     (req_addr),
        .req_size_i     (req_size),
        .req_signed_i   (req_signed),
        .req_wdata_i    (req_wdata),
        .req_strb_i     (req_strb),
        .ready_o        (ready),
        .resp_valid_o   (resp_valid),
        .resp_hit_o     (resp_hit),
        .resp_rdata_o   (resp_rdata),
        .refill_valid_i (refill_valid),
        .refill_addr_i  (refill_addr),
        .refill_way_i   (refill_way),
        .refill_data_i  (refill_data),
        .commit_i       (commit),
        .sb_empty_o     (sb_empty)
    );

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [3:0] strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // pick the addressed bytes, then extend
    function automatic word_t load_value(input word_t w, input logic [31:0] addr,
                                         input mem_size_e size, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       res;
        b = w[8*addr[1:0] +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        case (size)
            SIZE_BYTE: res = sgn ? {{24{b[7]}}, b} : {24'h0, b};
            SIZE_HALF: res = sgn ? {{16{h[15]}}, h} : {16'h0, h};
            default:   res = w;
        endcase
        return res;
    endfunction

    task automatic add_row(input op_e op, input logic [31:0] addr, input mem_size_e size,
                           input logic sgn, input word_t data, input logic [3:0] strb,
                           input way_mask_t way, input logic exp_hit, input word_t exp_data);
        table_q.push_back(row_t'{op, addr, size, sgn, data, strb, way, exp_hit, exp_data});
    endtask

    task automatic refill_row(input logic [31:0] addr, input way_mask_t way, input word_t data);
        add_row(OP_REFILL, addr, SIZE_WORD, 1'b0, data, 4'h0, way, 1'b0, '0);
    endtask

    task automatic hit_load(input logic [31:0] addr, input mem_size_e size, input logic sgn,
                            input word_t word);
        add_row(OP_LOAD, addr, size, sgn, '0, 4'h0, '0, 1'b1, load_value(word, addr, size, sgn));
    endtask

    task automatic miss_load(input logic [31:0] addr, input mem_size_e size);
        add_row(OP_LOAD, addr, size, 1'b0, '0, 4'h0, '0, 1'b0, '0);
    endtask

    task automatic store_row(input logic [31:0] addr, input word_t data, input logic [3:0] strb,
                             input logic exp_hit);
        add_row(OP_STORE, addr, SIZE_WORD, 1'b0, data, strb, '0, exp_hit, '0);
    endtask

    task automatic ctrl_row(input op_e op);
        add_row(op, '0, SIZE_WORD, 1'b0, '0, 4'h0, '0, 1'b0, '0);
    endtask

    task automatic build_table();
        for (int i = 0; i < 5; i++) begin
            refill_words[i] = $random(seed);
        end
        // known signs for the sign extension rows
        refill_words[0] = refill_words[0] | 32'h8000_0080;
        refill_words[2] = refill_words[2] & 32'h7fff_7fff;
        for (int i = 0; i < 4; i++) begin
            line_a[i] = refill_words[i];
        end
        line_b = refill_words[4];

        for (int i = 0; i < 4; i++) begin
            refill_row(LINE_A + 4 * i, 2'b10, line_a[i]);
        end
        refill_row(LINE_B, 2'b01, line_b);

        hit_load(LINE_A, SIZE_WORD, 1'b0, line_a[0]);
        hit_load(LINE_A + 4, SIZE_WORD, 1'b0, line_a[1]);
        hit_load(LINE_A + 2, SIZE_HALF, 1'b1, line_a[0]);
        hit_load(LINE_A + 2, SIZE_HALF, 1'b0, line_a[0]);
        hit_load(LINE_A + 8, SIZE_HALF, 1'b1, line_a[2]);
        hit_load(LINE_A, SIZE_BYTE, 1'b1, line_a[0]);
        hit_load(LINE_A, SIZE_BYTE, 1'b0, line_a[0]);
        hit_load(LINE_A + 3, SIZE_BYTE, 1'b1, line_a[0]);
        hit_load(LINE_A + 9, SIZE_BYTE, 1'b1, line_a[2]);
        hit_load(LINE_A + 13, SIZE_BYTE, 1'b0, line_a[3]);
        hit_load(LINE_B, SIZE_WORD, 1'b0, line_b);

        miss_load(32'h1234_5490, SIZE_WORD);
        miss_load(32'h5678_9450, SIZE_WORD);
        miss_load(32'h5678_9452, SIZE_BYTE);

        // forwarding before commit, the later byte store wins
        store_row(LINE_A + 4, 32'hA5A5_C3C3, 4'b0011, 1'b1);
        line_a[1] = merge_bytes(line_a[1], 32'hA5A5_C3C3, 4'b0011);
        hit_load(LINE_A + 4, SIZE_WORD, 1'b0, line_a[1]);
        store_row(LINE_A + 5, 32'h0000_7E00, 4'b0010, 1'b1);
        line_a[1] = merge_bytes(line_a[1], 32'h0000_7E00, 4'b0010);
        hit_load(LINE_A + 4, SIZE_WORD, 1'b0, line_a[1]);
        hit_load(LINE_A + 4, SIZE_BYTE, 1'b1, line_a[1]);
        hit_load(LINE_A + 5, SIZE_BYTE, 1'b1, line_a[1]);
        store_row(MISS_ST, 32'hCAFE_F00D, 4'b1111, 1'b0);
        hit_load(MISS_ST, SIZE_WORD, 1'b0, 32'hCAFE_F00D);
        hit_load(MISS_ST + 3, SIZE_BYTE, 1'b0, 32'hCAFE_F00D);

        repeat (3) ctrl_row(OP_COMMIT);
        ctrl_row(OP_DRAIN);
        hit_load(LINE_A + 4, SIZE_WORD, 1'b0, line_a[1]);
        miss_load(MISS_ST, SIZE_WORD);
        hit_load(LINE_B, SIZE_WORD, 1'b0, line_b);

        // fill the buffer, then hold a load until one commit
        store_row(LINE_A + 8, 32'h1357_9BDF, 4'b1111, 1'b1);
        line_a[2] = 32'h1357_9BDF;
        store_row(LINE_A + 12, 32'h2468_ACE0, 4'b1111, 1'b1);
        line_a[3] = 32'h2468_ACE0;
        store_row(LINE_A, 32'hBEEF_0000, 4'b1100, 1'b1);
        line_a[0] = merge_bytes(line_a[0], 32'hBEEF_0000, 4'b1100);
        store_row(LINE_A, 32'h0000_0011, 4'b0001, 1'b1);
        line_a[0] = merge_bytes(line_a[0], 32'h0000_0011, 4'b0001);
        ctrl_row(OP_IDLE);
        add_row(OP_HELD_LOAD, LINE_A + 8, SIZE_WORD, 1'b0, '0, 4'h0, '0, 1'b1, line_a[2]);
        repeat (3) ctrl_row(OP_COMMIT);
        ctrl_row(OP_DRAIN);
        hit_load(LINE_A, SIZE_WORD, 1'b0, line_a[0]);
        hit_load(LINE_A + 2, SIZE_HALF, 1'b1, line_a[0]);
        hit_load(LINE_A + 14, SIZE_HALF, 1'b1, line_a[3]);
        hit_load(LINE_A + 12, SIZE_WORD, 1'b0, line_a[3]);
        hit_load(LINE_A + 4, SIZE_WORD, 1'b0, line_a[1]);
    endtask

    function automatic void check_response(input row_t r, input int idx, input int latency);
        if (latency != 2) begin
            $display("ERROR at time %0t: row %0d response after %0d cycles, expected 2",
                     $time, idx, latency);
            value_errors++;
        end
        if (resp_hit !== r.exp_hit) begin
            $display("ERROR at time %0t: row %0d hit %b, expected %b",
                     $time, idx, resp_hit, r.exp_hit);
            value_errors++;
        end
        if (r.op == OP_STORE) begin
            if (resp_rdata !== 32'h0) begin
                $display("ERROR at time %0t: row %0d store data %h, expected 0",
                         $time, idx, resp_rdata);
                value_errors++;
            end
        end else if (r.exp_hit && resp_rdata !== r.exp_data) begin
            $display("ERROR at time %0t: row %0d load data %h, expected %h",
                     $time, idx, resp_rdata, r.exp_data);
            value_errors++;
        end
    endfunction

    task automatic run_request(input row_t r, input int idx, input logic held);
        int latency;
        @(negedge clk);
        req_valid  = 1'b1;
        req_addr   = r.addr;
        req_size   = r.size;
        req_signed = r.sgn;
        req_wdata  = r.data;
        req_strb   = r.strb;
        if (held) begin
            if (ready !== 1'b0) begin
                $display("ERROR at time %0t: row %0d ready_o high with a full store buffer",
                         $time, idx);
                value_errors++;
            end
            // one commit frees the oldest slot
            commit = 1'b1;
            @(negedge clk);
            commit = 1'b0;
        end
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        req_strb  = 4'h0;
        // this falling edge lies one cycle after acceptance
        latency = 1;
        while (resp_valid !== 1'b1 && latency < 4) begin
            @(negedge clk);
            latency++;
        end
        if (resp_valid !== 1'b1) begin
            $display("no response for row %0d within 4 cycles of acceptance", idx);
            other_errors++;
        end else begin
            check_response(r, idx, latency);
        end
    endtask

    task automatic run_refill(input row_t r);
        @(negedge clk);
        refill_valid = 1'b1;
        refill_addr  = r.addr;
        refill_way   = r.way;
        refill_data  = r.data;
        @(negedge clk);
        refill_valid = 1'b0;
    endtask

    task automatic pulse_commit();
        @(negedge clk);
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (sb_empty !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // run limit from the table length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (max_cycles > 0 && cycle_count >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        req_valid    = 1'b0;
        req_addr     = '0;
        req_size     = SIZE_WORD;
        req_signed   = 1'b0;
        req_wdata    = '0;
        req_strb     = 4'h0;
        refill_valid = 1'b0;
        refill_addr  = '0;
        refill_way   = '0;
        refill_data  = '0;
        commit       = 1'b0;
        seed         = 32'hb190_a350;
        build_table();
        max_cycles = 20 * table_q.size();

        wait (rst_n === 1'b1);
        @(negedge clk);
        if (resp_valid !== 1'b0 || ready !== 1'b1 || sb_empty !== 1'b1) begin
            $display("ERROR at time %0t: after reset resp_valid %b ready %b sb_empty %b",
                     $time, resp_valid, ready, sb_empty);
            value_errors++;
        end

        foreach (table_q[i]) begin
            case (table_q[i].op)
                OP_LOAD, OP_STORE: run_request(table_q[i], i, 1'b0);
                OP_HELD_LOAD:      run_request(table_q[i], i, 1'b1);
                OP_REFILL:         run_refill(table_q[i]);
                OP_COMMIT:         pulse_commit();
                OP_DRAIN:          wait_drained();
                default:           @(negedge clk);
            endcase
        end
        repeat (2) @(negedge clk);

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // synchronous reset, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* source/dcache_top.sv */
`include "dcache_params.svh"

module dcache_top
    import cache_pkg::*;
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid_i,
    input  logic [31:0] req_addr_i,
    input  mem_size_e   req_size_i,
    input  logic        req_signed_i,
    input  word_t       req_wdata_i,
    input  logic [3:0]  req_strb_i,
    output logic        ready_o,
    output logic        resp_valid_o,
    output logic        resp_hit_o,
    output word_t       resp_rdata_o,
    input  logic        refill_valid_i,
    input  logic [31:0] refill_addr_i,
    input  way_mask_t   refill_way_i,
    input  word_t       refill_data_i,
    input  logic        commit_i,
    output logic        sb_empty_o
);

    tag_entry_t [`DC_WAYS-1:0]      tag_rdata0, tag_rdata1;
    word_t [`DC_WAYS-1:0]           data_rdata0, data_rdata1;
    sb_entry_t [`DC_SB_DEPTH-1:0]   sb_entries;
    sb_entry_t                      sb_push_entry, sb_head;
    logic [31:0]                    rd_addr, wr_addr, drain_addr;
    logic                           rd_en, wr_valid, sb_push, sb_pop, sb_full, pending;
    logic [`DC_WAYS-1:0][3:0]       drain_we;
    word_t                          drain_wdata, wr_data;
    tag_entry_t                     refill_tag;

    // refill has priority on port 1
    assign wr_addr  = refill_valid_i ? refill_addr_i : drain_addr;
    assign wr_data  = refill_valid_i ? refill_data_i : drain_wdata;
    assign wr_valid = refill_valid_i || (|drain_we);

    always_comb begin
        refill_tag       = '0;
        refill_tag.valid = 1'b1;
        refill_tag.tag   = refill_addr_i[31:`DC_TAG_LO];
    end

    dcache_pipe u_pipe (
        .clk, .rst_n,
        .req_valid_i, .req_addr_i, .req_size_i, .req_signed_i, .req_wdata_i, .req_strb_i,
        .tag_rdata0_i (tag_rdata0),  .data_rdata0_i(data_rdata0),
        .tag_rdata1_i (tag_rdata1),  .data_rdata1_i(data_rdata1),
        .wr_addr_i    (wr_addr),     .wr_valid_i   (wr_valid),
        .sb_entries_i (sb_entries),  .sb_full_i    (sb_full),
        .ready_o,
        .rd_addr_o    (rd_addr),     .rd_en_o      (rd_en),
        .sb_push_o    (sb_push),     .sb_entry_o   (sb_push_entry),
        .resp_valid_o, .resp_hit_o, .resp_rdata_o
    );

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dual_port_ram #(.elem_t(tag_entry_t), .DEPTH(`DC_SETS), .LANES(1)) u_tag_ram (
            .clk, .rst_n,
            .addr0_i (rd_addr[`DC_INDEX_HI:`DC_INDEX_LO]), .en0_i(rd_en),
            .addr1_i (wr_addr[`DC_INDEX_HI:`DC_INDEX_LO]),
            .we1_i   (refill_valid_i && refill_way_i[w]),
            .wdata1_i(refill_tag),
            .rdata0_o(tag_rdata0[w]), .rdata1_o(tag_rdata1[w])
        );

        dual_port_ram #(
            .elem_t(word_t), .DEPTH(`DC_SETS * `DC_LINE_WORDS), .LANES(4)
        ) u_data_ram (
            .clk, .rst_n,
            .addr0_i (rd_addr[`DC_INDEX_HI:`DC_WORD_LO]), .en0_i(rd_en),
            .addr1_i (wr_addr[`DC_INDEX_HI:`DC_WORD_LO]),
            .we1_i   (refill_valid_i ? {4{refill_way_i[w]}} : drain_we[w]),
            .wdata1_i(wr_data),
            .rdata0_o(data_rdata0[w]), .rdata1_o(data_rdata1[w])
        );
    end

    store_buffer u_sb (
        .clk, .rst_n,
        .push_i(sb_push), .push_entry_i(sb_push_entry), .pop_i(sb_pop),
        .head_o(sb_head), .entries_o(sb_entries), .full_o(sb_full), .empty_o(sb_empty_o)
    );

    commit_counter u_commit (
        .clk, .rst_n, .inc_i(commit_i), .dec_i(sb_pop), .pending_o(pending)
    );

    drain_fsm u_drain (
        .clk, .rst_n,
        .pending_i(pending), .sb_empty_i(sb_empty_o), .refill_valid_i, .head_i(sb_head),
        .pop_o(sb_pop), .ram_we_o(drain_we), .ram_addr_o(drain_addr), .ram_wdata_o(drain_wdata)
    );

endmodule

/* dcache/dcache_pipe.sv */
`include "dcache_params.svh"

module dcache_pipe
    import cache_pkg::*;
    import lsu_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid_i,
    input  logic [31:0]                   req_addr_i,
    input  mem_size_e                     req_size_i,
    input  logic                          req_signed_i,
    input  word_t                         req_wdata_i,
    input  logic [3:0]                    req_strb_i,
    input  tag_entry_t [`DC_WAYS-1:0]     tag_rdata0_i,
    input  word_t [`DC_WAYS-1:0]          data_rdata0_i,
    input  tag_entry_t [`DC_WAYS-1:0]     tag_rdata1_i,
    input  word_t [`DC_WAYS-1:0]          data_rdata1_i,
    input  logic [31:0]                   wr_addr_i,
    input  logic                          wr_valid_i,
    input  sb_entry_t [`DC_SB_DEPTH-1:0]  sb_entries_i,
    input  logic                          sb_full_i,
    output logic                          ready_o,
    output logic [31:0]                   rd_addr_o,
    output logic                          rd_en_o,
    output logic                          sb_push_o,
    output sb_entry_t                     sb_entry_o,
    output logic                          resp_valid_o,
    output logic                          resp_hit_o,
    output word_t                         resp_rdata_o
);

    logic        accept;
    logic        m1_valid_q, m1_tag_conf_q, m1_data_conf_q;
    logic [31:0] m1_addr_q;
    mem_size_e   m1_size_q;
    logic        m1_signed_q;
    word_t       m1_wdata_q;
    logic [3:0]  m1_strb_q;
    logic        m1_store;

    tag_entry_t [`DC_WAYS-1:0] tag_m1;
    word_t [`DC_WAYS-1:0]      data_m1;
    way_mask_t                 tag_hit;
    word_t                     ram_word, sb_word, merged;
    logic [3:0]                sb_hit;

    logic        m2_valid_q, m2_signed_q, m2_store_q, m2_tag_hit_q;
    word_t       m2_word_q, shifted;
    logic [1:0]  m2_off_q;
    mem_size_e   m2_size_q;
    logic [3:0]  m2_byte_ok_q, rmask;

    assign m1_store = m1_valid_q && (|m1_strb_q);

    // hold off while a pushing store could overflow the buffer
    assign ready_o   = !(sb_full_i || (m1_store && sb_entries_i[`DC_SB_DEPTH-2].valid));
    assign accept    = req_valid_i && ready_o;
    assign rd_addr_o = req_addr_i;
    assign rd_en_o   = accept;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid_q     <= 1'b0;
            m1_tag_conf_q  <= 1'b0;
            m1_data_conf_q <= 1'b0;
        end else begin
            m1_valid_q <= accept;
            // same-cycle write to the read index, take port 1 next cycle
            m1_tag_conf_q  <= accept && wr_valid_i &&
                (req_addr_i[`DC_INDEX_HI:`DC_INDEX_LO] == wr_addr_i[`DC_INDEX_HI:`DC_INDEX_LO]);
            m1_data_conf_q <= accept && wr_valid_i &&
                (req_addr_i[`DC_INDEX_HI:`DC_WORD_LO] == wr_addr_i[`DC_INDEX_HI:`DC_WORD_LO]);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m1_addr_q   <= req_addr_i;
            m1_size_q   <= req_size_i;
            m1_signed_q <= req_signed_i;
            m1_wdata_q  <= req_wdata_i;
            m1_strb_q   <= req_strb_i;
        end
    end

    // tag compare, ways are one-hot on a hit
    always_comb begin
        ram_word = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            tag_m1[w]  = m1_tag_conf_q ? tag_rdata1_i[w] : tag_rdata0_i[w];
            data_m1[w] = m1_data_conf_q ? data_rdata1_i[w] : data_rdata0_i[w];
            tag_hit[w] = tag_m1[w].valid && (tag_m1[w].tag == m1_addr_q[31:`DC_TAG_LO]);
            if (tag_hit[w]) begin
                ram_word = ram_word | data_m1[w];
            end
        end
    end

    // oldest first, so the youngest matching store wins each byte
    always_comb begin
        sb_hit  = '0;
        sb_word = '0;
        for (int i = 0; i < `DC_SB_DEPTH; i++) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_entries_i[i].valid && sb_entries_i[i].strb[b] &&
                    (sb_entries_i[i].addr[31:2] == m1_addr_q[31:2])) begin
                    sb_hit[b]         = 1'b1;
                    sb_word[8*b +: 8] = sb_entries_i[i].data[8*b +: 8];
                end
            end
        end
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = sb_hit[b] ? sb_word[8*b +: 8] : ram_word[8*b +: 8];
        end
    end

    assign sb_push_o = m1_store;

    always_comb begin
        sb_entry_o       = '0;
        sb_entry_o.valid = 1'b1;
        sb_entry_o.addr  = {m1_addr_q[31:2], 2'b00};
        sb_entry_o.data  = m1_wdata_q;
        sb_entry_o.strb  = m1_strb_q;
        sb_entry_o.way   = tag_hit;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2_valid_q <= 1'b0;
        end else begin
            m2_valid_q <= m1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        m2_word_q    <= merged;
        m2_off_q     <= m1_addr_q[1:0];
        m2_size_q    <= m1_size_q;
        m2_signed_q  <= m1_signed_q;
        m2_store_q   <= |m1_strb_q;
        m2_tag_hit_q <= |tag_hit;
        m2_byte_ok_q <= sb_hit | {4{|tag_hit}};
    end

    // read mask and right alignment
    assign shifted = m2_word_q >> {m2_off_q, 3'b000};

    always_comb begin
        case (m2_size_q)
            SIZE_BYTE: rmask = 4'b0001 << m2_off_q;
            SIZE_HALF: rmask = 4'b0011 << {m2_off_q[1], 1'b0};
            default:   rmask = 4'b1111;
        endcase
    end

    always_comb begin
        if (m2_store_q) begin
            resp_rdata_o = '0;
        end else begin
            case (m2_size_q)
                SIZE_BYTE: resp_rdata_o = {{24{m2_signed_q & shifted[7]}}, shifted[7:0]};
                SIZE_HALF: resp_rdata_o = {{16{m2_signed_q & shifted[15]}}, shifted[15:0]};
                default:   resp_rdata_o = shifted;
            endcase
        end
    end

    assign resp_valid_o = m2_valid_q;
    assign resp_hit_o   = m2_store_q ? m2_tag_hit_q : ((rmask & ~m2_byte_ok_q) == 4'b0000);

endmodule

/* source/drain_fsm.sv */
`include "dcache_params.svh"

module drain_fsm
    import cache_pkg::*;
    import lsu_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pending_i,
    input  logic                          sb_empty_i,
    input  logic                          refill_valid_i,
    input  sb_entry_t                     head_i,
    output logic                          pop_o,
    output logic [`DC_WAYS-1:0][3:0]      ram_we_o,
    output logic [31:0]                   ram_addr_o,
    output word_t                         ram_wdata_o
);

    typedef enum logic {
        S_IDLE,
        S_WRITE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   drain_go;

    // refill owns the write port in its cycle
    assign drain_go = (state_q == S_WRITE) && !refill_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (pending_i && !sb_empty_i && !refill_valid_i) state_d = S_WRITE;
            S_WRITE: if (drain_go) state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a miss store pops with no lane enabled
    always_comb begin
        ram_we_o = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (drain_go && head_i.way[w]) begin
                ram_we_o[w] = head_i.strb;
            end
        end
    end

    assign pop_o       = drain_go;
    assign ram_addr_o  = head_i.addr;
    assign ram_wdata_o = head_i.data;

endmodule

/* source/commit_counter.sv */
`include "dcache_params.svh"

module commit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic inc_i,
    input  logic dec_i,
    output logic pending_o
);

    localparam int CW = $clog2(`DC_SB_DEPTH + 1);

    logic [CW-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            case ({inc_i, dec_i})
                2'b10: begin
                    // saturate at buffer depth
                    if (count_q != CW'(`DC_SB_DEPTH)) begin
                        count_q <= count_q + 1'b1;
                    end
                end
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign pending_o = |count_q;

    // a drain always follows a commit
    a_no_dec_zero: assert property (
        @(posedge clk) disable iff (!rst_n) dec_i |-> pending_o
    );

endmodule

/* store_buffer/store_buffer.sv */
`include "dcache_params.svh"

module store_buffer
    import lsu_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push_i,
    input  sb_entry_t                     push_entry_i,
    input  logic                          pop_i,
    output sb_entry_t                     head_o,
    output sb_entry_t [`DC_SB_DEPTH-1:0]  entries_o,
    output logic                          full_o,
    output logic                          empty_o
);

    localparam int D  = `DC_SB_DEPTH;
    localparam int PW = $clog2(D);

    sb_entry_t [D-1:0] slot_q;
    logic [PW-1:0]     head_q;
    logic [PW-1:0]     tail_q;
    logic [PW:0]       count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // new entry lands at the tail
    always_ff @(posedge clk) begin
        if (push_i) begin
            slot_q[tail_q] <= push_entry_i;
        end
    end

    // index 0 is the oldest, valid comes from the occupancy
    always_comb begin
        for (int i = 0; i < D; i++) begin
            entries_o[i]       = slot_q[head_q + PW'(i)];
            entries_o[i].valid = (count_q > (PW+1)'(i));
        end
    end

    assign head_o  = entries_o[0];
    assign full_o  = (count_q == (PW+1)'(D));
    assign empty_o = (count_q == '0);

    // ready_o and the drain FSM keep these from happening
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push_i |-> !full_o || pop_i
    );
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
    );

endmodule

/* source/dual_port_ram.sv */
module dual_port_ram #(
    parameter type elem_t = logic [31:0],
    parameter int  DEPTH  = 256,
    parameter int  LANES  = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] addr0_i,
    input  logic                     en0_i,
    input  logic [$clog2(DEPTH)-1:0] addr1_i,
    input  logic [LANES-1:0]         we1_i,
    input  elem_t                    wdata1_i,
    output elem_t                    rdata0_o,
    output elem_t                    rdata1_o
);

    localparam int W  = $bits(elem_t);
    localparam int LW = W / LANES;

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] wdata_bits;
    logic [W-1:0] wr_word;
    logic [W-1:0] rdata0_q;
    logic [W-1:0] rdata1_q;

    assign wdata_bits = wdata1_i;

    // merge the enabled lanes over the stored word
    always_comb begin
        wr_word = mem[addr1_i];
        for (int l = 0; l < LANES; l++) begin
            if (we1_i[l]) begin
                wr_word[l*LW +: LW] = wdata_bits[l*LW +: LW];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // valid bits start cleared
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata0_q <= '0;
            rdata1_q <= '0;
        end else begin
            if (|we1_i) begin
                mem[addr1_i] <= wr_word;
            end
            if (en0_i) begin
                rdata0_q <= mem[addr0_i];
            end
            // write-first read-back on port 1
            rdata1_q <= wr_word;
        end
    end

    assign rdata0_o = rdata0_q;
    assign rdata1_o = rdata1_q;

endmodule

/* common/lsu_pkg.sv */
package lsu_pkg;

    // access size, matches the core encoding
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // a store waiting for commit
    typedef struct packed {
        logic                valid;
        logic [31:0]         addr;
        cache_pkg::word_t    data;
        logic [3:0]          strb;
        // hit way at push time, zero on a miss
        cache_pkg::way_mask_t way;
    } sb_entry_t;

endpackage

/* common/cache_pkg.sv */
`include "dcache_params.svh"

package cache_pkg;

    // one tag RAM element
    typedef struct packed {
        logic                     valid;
        logic [31:`DC_TAG_LO]     tag;
    } tag_entry_t;

    // one-hot way select, zero means no way
    typedef logic [`DC_WAYS-1:0] way_mask_t;

    typedef logic [31:0] word_t;

endpackage

/* common/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DC_WAYS        2
`define DC_SETS        64
`define DC_LINE_WORDS  4
`define DC_SB_DEPTH    4

// address fields: set index [9:4], word index [9:2], tag [31:10]
`define DC_WORD_LO     2
`define DC_INDEX_LO    4
`define DC_INDEX_HI    9
`define DC_TAG_LO      10

`endif
